// File: Makefile
SRCS = $(shell cat verilog.f)

.PHONY: run clean

run: obj_dir/Vtb_gpio_lite
	./obj_dir/Vtb_gpio_lite +verilator+error+limit+100 2>&1 | tee sim.log
	@! grep -q '\*\*\* FAILED \*\*\*' sim.log
	@grep -q '\*\*\* PASSED \*\*\*' sim.log

obj_dir/Vtb_gpio_lite: verilog.f $(SRCS)
	verilator --binary --timing --assert -j 0 --top-module tb_gpio_lite -f verilog.f

clean:
	rm -rf obj_dir sim.log

// File: gpio_apb_fsm.sv
`timescale 1ns/1ps

module gpio_apb_fsm
   import gpio_pkg::*;
(
   input  logic     pclk,
   input  logic     arst_n,
   input  apb_req_t req,
   output logic     rd_stb,   // first setup cycle of a read
   output logic     wr_stb    // first access cycle of a write
);

   apb_state_t state;       // bus phase of the previous cycle
   apb_state_t state_nxt;
   logic       setup_ph;    // sel high, enable low
   logic       access_ph;   // sel and enable high

   assign setup_ph  = req.sel & ~req.enable;
   assign access_ph = req.sel & req.enable;

   // phase tracking
   always_comb
   begin
      if (setup_ph)
         state_nxt = st_setup;
      else if (access_ph)
         state_nxt = st_access;   // stays here while enable is held
      else
         state_nxt = st_idle;
   end

   always_ff @(posedge pclk or negedge arst_n)
   begin
      if (!arst_n)
         state <= st_idle;
      else
         state <= state_nxt;
   end

   // read data is captured at the end of setup, so strobe there
   assign rd_stb = setup_ph & ~req.write & (state != st_setup);

   // write only right after a setup cycle, one strobe per transfer
   assign wr_stb = access_ph & req.write & (state == st_setup);

endmodule

// File: gpio_checker.sv
`timescale 1ns/1ps

module gpio_checker
   import gpio_pkg::*;
(
   input logic       pclk,
   input logic       arst_n,
   input logic       rd_stb,
   input logic       wr_stb,
   input gpio_word_t tri_state_enable,
   input gpio_word_t oe_n
);

   int fail_cnt = 0;   // assertion failures so far

   // ------------------------------------------------------------
   // apb strobes
   // ------------------------------------------------------------
   a_strobe_excl : assert property (@(posedge pclk) disable iff (!arst_n)
                                    !(rd_stb && wr_stb))
   else
   begin
      $error("read and write strobe high in the same cycle");
      fail_cnt++;
   end

   a_rd_one_cycle : assert property (@(posedge pclk) disable iff (!arst_n)
                                     rd_stb |=> !rd_stb)
   else
   begin
      $error("read strobe longer than one cycle");
      fail_cnt++;
   end

   a_wr_one_cycle : assert property (@(posedge pclk) disable iff (!arst_n)
                                     wr_stb |=> !wr_stb)
   else
   begin
      $error("write strobe longer than one cycle");
      fail_cnt++;
   end

   // tri-state override on the pin drive
   a_tri_state : assert property (@(posedge pclk) disable iff (!arst_n)
                                  (tri_state_enable & ~oe_n) == '0)
   else
   begin
      $error("pin driven while tri_state_enable is high");
      fail_cnt++;
   end

endmodule

bind gpio_lite gpio_checker u_checker (
   .pclk             (pclk),
   .arst_n           (arst_n),
   .rd_stb           (rd_stb),
   .wr_stb           (wr_stb),
   .tri_state_enable (tri_state_enable),
   .oe_n             (n_gpio_pin_oe)
);

// File: gpio_int_ctrl.sv
`timescale 1ns/1ps

module gpio_int_ctrl
   import gpio_pkg::*;
(
   input  logic       pclk,
   input  logic       arst_n,
   input  gpio_word_t filtered,     // debounced pins
   input  int_cfg_t   cfg,          // enables and types
   input  gpio_word_t status_clr,   // write 1 to clear mask
   output gpio_word_t int_status,
   output logic       gpio_int
);

   gpio_word_t filt_prev;   // last cycle value, for edge detect
   gpio_word_t rise;
   gpio_word_t event_vec;   // per pin event this cycle

   assign rise = filtered & ~filt_prev;

   // level high for type 0, rising edge for type 1
   assign event_vec = (cfg.int_type & rise) | (~cfg.int_type & filtered);

   // ------------------------------------------------------------
   // sticky status and interrupt line
   // ------------------------------------------------------------
   always_ff @(posedge pclk or negedge arst_n)
   begin
      if (!arst_n)
      begin
         filt_prev  <= '0;
         int_status <= '0;
         gpio_int   <= 1'b0;
      end
      else
      begin
         filt_prev  <= filtered;
         int_status <= (int_status & ~status_clr) | event_vec;   // event beats clear
         gpio_int   <= |(int_status & cfg.int_en);   // one cycle behind status
      end
   end

endmodule

// File: gpio_lite.sv
`timescale 1ns/1ps

module gpio_lite
   import gpio_pkg::*;
(
   input  logic       pclk,
   input  logic       arst_n,
   input  logic       psel,
   input  logic       penable,
   input  logic       pwrite,
   input  apb_addr_t  paddr,
   input  apb_data_t  pwdata,
   input  gpio_word_t gpio_pin_in,
   input  gpio_word_t tri_state_enable,
   output apb_data_t  prdata,
   output logic       gpio_int,
   output gpio_word_t n_gpio_pin_oe,
   output gpio_word_t gpio_pin_out
);

   apb_req_t   req;
   logic       rd_stb;
   logic       wr_stb;
   logic       tick;
   gpio_word_t filtered;
   gpio_word_t rdata;
   gpio_word_t int_status;
   gpio_word_t status_clr;
   int_cfg_t   cfg;
   pin_drive_t drive;

   // ------------------------------------------------------------
   // bus side
   // ------------------------------------------------------------
   assign req = '{sel: psel, enable: penable, write: pwrite, addr: paddr, wdata: pwdata};

   gpio_apb_fsm u_apb_fsm (
      .pclk   (pclk),
      .arst_n (arst_n),
      .req    (req),
      .rd_stb (rd_stb),
      .wr_stb (wr_stb)
   );

   // upper bits unused, read as zero
   assign prdata = {{($bits(apb_data_t) - gpio_width){1'b0}}, rdata};

   // ------------------------------------------------------------
   // input path
   // ------------------------------------------------------------
   gpio_sample_timer u_sample_timer (
      .pclk   (pclk),
      .arst_n (arst_n),
      .tick   (tick)
   );

   gpio_pin_filter u_pin_filter (
      .pclk     (pclk),
      .arst_n   (arst_n),
      .tick     (tick),
      .pin_in   (gpio_pin_in),
      .filtered (filtered)
   );

   // ------------------------------------------------------------
   // registers and interrupts
   // ------------------------------------------------------------
   gpio_regs u_regs (
      .pclk             (pclk),
      .arst_n           (arst_n),
      .rd_stb           (rd_stb),
      .wr_stb           (wr_stb),
      .addr             (req.addr),
      .wdata            (req.wdata[gpio_width-1:0]),   // low half only
      .data_in          (filtered),
      .int_status       (int_status),
      .tri_state_enable (tri_state_enable),
      .rdata            (rdata),
      .cfg              (cfg),
      .drive            (drive),
      .status_clr       (status_clr)
   );

   gpio_int_ctrl u_int_ctrl (
      .pclk       (pclk),
      .arst_n     (arst_n),
      .filtered   (filtered),
      .cfg        (cfg),
      .status_clr (status_clr),
      .int_status (int_status),
      .gpio_int   (gpio_int)
   );

   assign gpio_pin_out  = drive.out;
   assign n_gpio_pin_oe = drive.oe_n;

endmodule

// File: gpio_pin_filter.sv
`timescale 1ns/1ps

module gpio_pin_filter
   import gpio_pkg::*;
(
   input  logic       pclk,
   input  logic       arst_n,
   input  logic       tick,       // sample strobe from the timer
   input  gpio_word_t pin_in,     // raw asynchronous pins
   output gpio_word_t filtered    // debounced value, feeds data_in
);

   // ------------------------------------------------------------
   // two flop synchronizer
   // ------------------------------------------------------------
   gpio_word_t sync_q1;
   gpio_word_t sync_q2;

   always_ff @(posedge pclk or negedge arst_n)
   begin
      if (!arst_n)
      begin
         sync_q1 <= '0;
         sync_q2 <= '0;
      end
      else
      begin
         sync_q1 <= pin_in;
         sync_q2 <= sync_q1;   // safe to use from here on
      end
   end

   // ------------------------------------------------------------
   // debounce, two consecutive samples must agree
   // ------------------------------------------------------------
   gpio_word_t sample_q;   // sample from the previous tick
   gpio_word_t agree;      // per pin, new sample equals stored one

   assign agree = ~(sync_q2 ^ sample_q);

   always_ff @(posedge pclk or negedge arst_n)
   begin
      if (!arst_n)
      begin
         sample_q <= '0;
         filtered <= '0;
      end
      else if (tick)
      begin
         sample_q <= sync_q2;
         filtered <= (filtered & ~agree) | (sync_q2 & agree);   // per bit update
      end
   end

endmodule

// File: gpio_pkg.sv
package gpio_pkg;

   // ------------------------------------------------------------
   // widths
   // ------------------------------------------------------------
   localparam int gpio_width   = 16;
   localparam int sample_div   = 4;                    // pclk cycles per sample tick
   localparam int sample_cnt_w = $clog2(sample_div);   // prescaler counter width

   typedef logic [gpio_width-1:0] gpio_word_t;  // one bit per pin
   typedef logic [5:0]            apb_addr_t;   // byte address
   typedef logic [31:0]           apb_data_t;

   // ------------------------------------------------------------
   // register map
   // ------------------------------------------------------------
   localparam apb_addr_t addr_data_out   = 6'h00;
   localparam apb_addr_t addr_dir        = 6'h04;  // 1 = output
   localparam apb_addr_t addr_data_in    = 6'h08;  // read only
   localparam apb_addr_t addr_int_en     = 6'h0C;
   localparam apb_addr_t addr_int_type   = 6'h10;  // 0 = level high, 1 = rising edge
   localparam apb_addr_t addr_int_status = 6'h14;  // write 1 to clear

   // one apb request as seen at the top level
   typedef struct packed {
      logic      sel;
      logic      enable;
      logic      write;
      apb_addr_t addr;
      apb_data_t wdata;
   } apb_req_t;

   typedef enum logic [1:0] {
      st_idle,
      st_setup,
      st_access
   } apb_state_t;

   typedef struct packed {
      gpio_word_t int_en;
      gpio_word_t int_type;
   } int_cfg_t;

   typedef struct packed {
      gpio_word_t out;
      gpio_word_t oe_n;   // active low enable
   } pin_drive_t;

endpackage

// File: gpio_regs.sv
`timescale 1ns/1ps

module gpio_regs
   import gpio_pkg::*;
(
   input  logic       pclk,
   input  logic       arst_n,
   input  logic       rd_stb,
   input  logic       wr_stb,
   input  apb_addr_t  addr,
   input  gpio_word_t wdata,              // low half of pwdata
   input  gpio_word_t data_in,            // filtered pins
   input  gpio_word_t int_status,         // sticky status from int ctrl
   input  gpio_word_t tri_state_enable,   // forces oe_n high per pin
   output gpio_word_t rdata,
   output int_cfg_t   cfg,
   output pin_drive_t drive,
   output gpio_word_t status_clr          // one cycle clear mask
);

   gpio_word_t data_out;
   gpio_word_t dir;
   gpio_word_t int_en;
   gpio_word_t int_type;
   gpio_word_t rd_mux;

   // ------------------------------------------------------------
   // write decode, at the access strobe
   // ------------------------------------------------------------
   always_ff @(posedge pclk or negedge arst_n)
   begin
      if (!arst_n)
      begin
         data_out <= '0;
         dir      <= '0;   // all pins input
         int_en   <= '0;
         int_type <= '0;
      end
      else if (wr_stb)
      begin
         case (addr)
            addr_data_out : data_out <= wdata;
            addr_dir      : dir      <= wdata;
            addr_int_en   : int_en   <= wdata;
            addr_int_type : int_type <= wdata;
            default       : ;   // data_in and status not stored here
         endcase
      end
   end

   // status is cleared in the int ctrl at the same edge
   assign status_clr = (wr_stb && addr == addr_int_status) ? wdata : '0;

   // ------------------------------------------------------------
   // read mux, captured at the setup strobe
   // ------------------------------------------------------------
   always_comb
   begin
      case (addr)
         addr_data_out   : rd_mux = data_out;
         addr_dir        : rd_mux = dir;
         addr_data_in    : rd_mux = data_in;
         addr_int_en     : rd_mux = int_en;
         addr_int_type   : rd_mux = int_type;
         addr_int_status : rd_mux = int_status;
         default         : rd_mux = '0;   // unmapped offsets
      endcase
   end

   always_ff @(posedge pclk or negedge arst_n)
   begin
      if (!arst_n)
         rdata <= '0;
      else if (rd_stb)
         rdata <= rd_mux;   // held through access and until next read
   end

   // ------------------------------------------------------------
   // config and pin drive
   // ------------------------------------------------------------
   assign cfg.int_en   = int_en;
   assign cfg.int_type = int_type;

   assign drive.out  = data_out;
   assign drive.oe_n = ~(dir & ~tri_state_enable);   // combinational override

endmodule

// File: gpio_sample_timer.sv
`timescale 1ns/1ps

module gpio_sample_timer
   import gpio_pkg::*;
(
   input  logic pclk,
   input  logic arst_n,
   output logic tick    // one pclk wide, every sample_div cycles
);

   // ------------------------------------------------------------
   // modulo prescaler
   // ------------------------------------------------------------
   logic [sample_cnt_w-1:0] cnt;

   assign tick = (cnt == sample_cnt_w'(sample_div - 1));   // last count

   always_ff @(posedge pclk or negedge arst_n)
   begin
      if (!arst_n)
      begin
         cnt <= '0;
      end
      else if (tick)
      begin
         cnt <= '0;                // wrap
      end
      else
      begin
         cnt <= cnt + 1'b1;
      end
   end

endmodule

// File: gpio_scoreboard.sv
`timescale 1ns/1ps

module gpio_scoreboard
   import gpio_pkg::*;
(
   input  logic       pclk,
   input  logic       arst_n,
   input  logic       psel,
   input  logic       penable,
   input  logic       pwrite,
   input  apb_addr_t  paddr,
   input  apb_data_t  pwdata,
   input  gpio_word_t gpio_pin_in,
   input  gpio_word_t tri_state_enable,
   input  apb_data_t  prdata,
   input  logic       gpio_int,
   input  gpio_word_t n_gpio_pin_oe,
   input  gpio_word_t gpio_pin_out,
   input  int         test_id,
   input  logic       test_end,   // one cycle pulse per finished test
   input  logic       report,     // print the closing counts
   output int         err_cnt
);

   localparam int settle_in = 2 + 2 * sample_div + 1;   // pin change to data_in
   localparam int settle_st = settle_in + 2;            // and on into status

   // ------------------------------------------------------------
   // reference model
   // ------------------------------------------------------------
   gpio_word_t m_dout;
   gpio_word_t m_dir;
   gpio_word_t m_en;
   gpio_word_t m_type;
   gpio_word_t m_status;
   gpio_word_t cand;        // pin word being timed
   gpio_word_t settled;     // last pin word past the bound
   int         run;         // cycles cand has been on the pins
   logic       glitch;      // single cycle excursion in progress
   logic       was_setup;
   logic       rd_pend;     // read data due at this edge
   logic       rd_known;
   apb_data_t  rd_exp;
   logic       int_known;
   logic       int_exp;
   logic       int_known_nxt;   // one edge further out
   logic       int_exp_nxt;
   int         checks;
   int         test_errs;
   int         tests;

   function automatic string test_name(input int id);
      case (id)
         1       : return "reset values";
         2       : return "register access";
         3       : return "pin drive";
         4       : return "input filter";
         5       : return "interrupts";
         default : return "unknown";
      endcase
   endfunction

   task automatic check(input logic ok, input string msg);
      checks++;
      if (!ok)
      begin
         err_cnt++;
         test_errs++;
         $display("** Error at %0t ns: %s", $time, msg);
      end
   endtask

   always @(posedge pclk or negedge arst_n)
   begin
      gpio_word_t clr;
      gpio_word_t rd_val;
      logic       wr;
      if (!arst_n)
      begin
         m_dout        = '0;
         m_dir         = '0;
         m_en          = '0;
         m_type        = '0;
         m_status      = '0;
         cand          = '0;
         settled       = '0;
         run           = settle_st;   // pins held low through reset
         glitch        = 1'b0;
         was_setup     = 1'b0;
         rd_pend       = 1'b0;
         rd_known      = 1'b0;
         rd_exp        = '0;
         int_known     = 1'b1;
         int_exp       = 1'b0;
         int_known_nxt = 1'b1;
         int_exp_nxt   = 1'b0;
         err_cnt       = 0;
         checks        = 0;
         test_errs     = 0;
         tests         = 0;
      end
      else
      begin
         // outputs as they stand just before this edge
         check(gpio_pin_out === m_dout,
               $sformatf("gpio_pin_out %h, expected %h", gpio_pin_out, m_dout));
         check(n_gpio_pin_oe === ~(m_dir & ~tri_state_enable),
               $sformatf("n_gpio_pin_oe %h, dir %h tri %h", n_gpio_pin_oe, m_dir,
                         tri_state_enable));
         if (int_known)
            check(gpio_int === int_exp, $sformatf("gpio_int %b, expected %b", gpio_int, int_exp));
         if (rd_pend && rd_known)
            check(prdata === rd_exp, $sformatf("prdata %h, expected %h", prdata, rd_exp));
         rd_pend = 1'b0;

         // pin word timing, one cycle excursions rejected once settled
         if (gpio_pin_in == cand)
         begin
            run++;
            glitch = 1'b0;
         end
         else if (run >= settle_in && !glitch)
            glitch = 1'b1;
         else
         begin
            cand   = gpio_pin_in;
            run    = 1;
            glitch = 1'b0;
         end
         if (run == settle_st)
         begin
            m_status |= (m_type & cand & ~settled) | (~m_type & cand);   // events of the change
            settled = cand;
         end

         // -------------------------------------------------------
         // bus decode
         // -------------------------------------------------------
         wr  = psel & penable & pwrite & was_setup;
         clr = (wr && paddr == addr_int_status) ? pwdata[gpio_width-1:0] : '0;
         if (psel && !penable && !pwrite && !was_setup)
         begin
            rd_pend  = 1'b1;
            rd_known = 1'b1;
            case (paddr)
               addr_data_out   : rd_val = m_dout;
               addr_dir        : rd_val = m_dir;
               addr_int_en     : rd_val = m_en;
               addr_int_type   : rd_val = m_type;
               addr_data_in    :
               begin
                  rd_val   = cand;
                  rd_known = (run >= settle_in);   // only past the bound
               end
               addr_int_status :
               begin
                  rd_val   = m_status;
                  rd_known = (run >= settle_st);
               end
               default         : rd_val = '0;
            endcase
            rd_exp = apb_data_t'(rd_val);   // upper half reads zero
         end

         m_status &= ~clr;
         if (run >= settle_st)
            m_status |= ~m_type & settled;   // level events win over the clear

         if (wr)
         begin
            case (paddr)
               addr_data_out : m_dout = pwdata[gpio_width-1:0];
               addr_dir      : m_dir  = pwdata[gpio_width-1:0];
               addr_int_en   : m_en   = pwdata[gpio_width-1:0];
               addr_int_type : m_type = pwdata[gpio_width-1:0];
               default       : ;
            endcase
         end

         // gpio_int registers status and enable, seen two edges from here
         int_known     = int_known_nxt;
         int_exp       = int_exp_nxt;
         int_known_nxt = (run >= settle_st);
         int_exp_nxt   = |(m_status & m_en);
         was_setup     = psel & ~penable;

         if (test_end)
         begin
            tests++;
            $display("test %0d %s: %0d errors", test_id, test_name(test_id), test_errs);
            test_errs = 0;
         end
         if (report)
            $display("%0d tests, %0d checks, %0d errors", tests, checks, err_cnt);
      end
   end

endmodule

// File: tb_gpio_lite.sv
`timescale 1ns/1ps

module tb_gpio_lite
   import gpio_pkg::*;
();

   localparam int max_cycles = 4000;   // about four times the summed test lengths

   logic       pclk;
   logic       arst_n;
   logic       psel;
   logic       penable;
   logic       pwrite;
   apb_addr_t  paddr;
   apb_data_t  pwdata;
   gpio_word_t gpio_pin_in;
   gpio_word_t tri_state_enable;
   apb_data_t  prdata;
   logic       gpio_int;
   gpio_word_t n_gpio_pin_oe;
   gpio_word_t gpio_pin_out;
   int         test_id;
   logic       test_end;
   logic       report;
   int         err_cnt;
   int         cycles = 0;
   gpio_word_t val;
   apb_addr_t  addr_r;

   gpio_lite u_gpio_lite (.*);

   gpio_scoreboard u_scoreboard (.*);

   always #10 pclk = ~pclk;   // 20 ns period

   // run limit
   always @(posedge pclk)
   begin
      cycles++;
      if (cycles >= max_cycles)
      begin
         $display("timeout: run did not finish within %0d cycles", max_cycles);
         $display("*** FAILED ***");
         $finish;
      end
   end

   function automatic gpio_word_t rand_word();
      return gpio_word_t'($urandom);
   endfunction

   // ------------------------------------------------------------
   // apb phases, inputs move on the falling edge
   // ------------------------------------------------------------
   task automatic apb_write(input apb_addr_t addr, input apb_data_t data);
      @(negedge pclk);
      psel    = 1'b1;   // setup
      penable = 1'b0;
      pwrite  = 1'b1;
      paddr   = addr;
      pwdata  = data;
      @(negedge pclk);
      penable = 1'b1;   // access
      @(negedge pclk);
      psel    = 1'b0;
      penable = 1'b0;
   endtask

   task automatic apb_read(input apb_addr_t addr);
      @(negedge pclk);
      psel    = 1'b1;
      penable = 1'b0;
      pwrite  = 1'b0;
      paddr   = addr;
      @(negedge pclk);
      penable = 1'b1;   // prdata valid here, checked by the scoreboard
      @(negedge pclk);
      psel    = 1'b0;
      penable = 1'b0;
   endtask

   task automatic close_test();
      @(negedge pclk);
      test_end = 1'b1;
      @(negedge pclk);
      test_end = 1'b0;
      test_id++;
   endtask

   initial
   begin
      void'($urandom(65064));
      pclk             = 1'b0;
      arst_n           = 1'b0;
      psel             = 1'b0;
      penable          = 1'b0;
      pwrite           = 1'b0;
      paddr            = '0;
      pwdata           = '0;
      gpio_pin_in      = '0;
      tri_state_enable = '0;
      test_id          = 1;
      test_end         = 1'b0;
      report           = 1'b0;
      repeat (2) @(negedge pclk);
      arst_n = 1'b1;

      // reset values at every offset
      for (int a = 0; a < 32; a += 4)
         apb_read(apb_addr_t'(a));
      close_test();

      // random write then read back, 40 transfers
      for (int i = 0; i < 20; i++)
      begin
         addr_r = apb_addr_t'($urandom_range(7) << 2);
         apb_write(addr_r, $urandom);
         apb_read(addr_r);
      end
      close_test();

      // pin drive with tri-state override
      for (int i = 0; i < 20; i++)
      begin
         apb_write(addr_dir, $urandom);
         apb_write(addr_data_out, $urandom);
         tri_state_enable = rand_word();
         repeat (2) @(negedge pclk);
      end
      tri_state_enable = '0;
      close_test();

      // input filter, 20 cycle holds with a mid hold glitch
      for (int i = 0; i < 12; i++)
      begin
         val         = rand_word();
         gpio_pin_in = val;
         repeat (12) @(negedge pclk);
         gpio_pin_in = val ^ rand_word();   // one cycle only
         @(negedge pclk);
         gpio_pin_in = val;
         repeat (4) @(negedge pclk);
         apb_read(addr_data_in);
      end
      close_test();

      // interrupts
      for (int i = 0; i < 4; i++)
      begin
         gpio_pin_in = '0;
         repeat (16) @(negedge pclk);
         apb_write(addr_int_en, $urandom);
         apb_write(addr_int_type, $urandom);
         apb_write(addr_int_status, '1);   // start clean
         val         = rand_word();
         gpio_pin_in = val;                // level and rising events
         repeat (16) @(negedge pclk);
         apb_read(addr_int_status);
         apb_write(addr_int_status, '1);   // level bits stay set
         apb_read(addr_int_status);
         apb_write(addr_int_type, '1);     // all rising edge
         gpio_pin_in = '0;
         repeat (16) @(negedge pclk);
         apb_write(addr_int_status, '1);
         gpio_pin_in = val;
         repeat (16) @(negedge pclk);
         gpio_pin_in = '0;
         repeat (16) @(negedge pclk);
         apb_read(addr_int_status);        // sticky after the fall
         apb_write(addr_int_status, apb_data_t'(val));
         apb_read(addr_int_status);
      end
      close_test();

      report = 1'b1;
      @(negedge pclk);
      report = 1'b0;
      if (err_cnt == 0 && u_gpio_lite.u_checker.fail_cnt == 0)
         $display("*** PASSED ***");
      else
         $display("*** FAILED ***");
      $finish;
   end

endmodule

// File: verilog.f
gpio_pkg.sv
gpio_apb_fsm.sv
gpio_sample_timer.sv
gpio_pin_filter.sv
gpio_regs.sv
gpio_int_ctrl.sv
gpio_lite.sv
gpio_checker.sv
gpio_scoreboard.sv
tb_gpio_lite.sv
